/* board_specific_top.f */
source/mic_meter_pkg.sv
source/display_if.sv
source/inmp441_mic_i2s_receiver.sv
source/level_meter.sv
source/tm1638_board_controller.sv
source/board_specific_top.sv
verif/tb_clock_gen.sv
verif/tb_board_specific_top.sv

/* Bender.yml */
package:
  name: mic_meter

sources:
  - source/mic_meter_pkg.sv
  - source/display_if.sv
  - source/inmp441_mic_i2s_receiver.sv
  - source/level_meter.sv
  - source/tm1638_board_controller.sv
  - source/board_specific_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_board_specific_top.sv

/* verif/tb_board_specific_top.sv */
`default_nettype none

module tb_board_specific_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int sck_half    = 2;
    localparam int sio_half    = 2;
    localparam int n_samples   = 240;   // Microphone frames over the whole run
    localparam int cycle_limit = 2 * (n_samples * 64 * 2 * sck_half + 10 * 200 * 2 * sio_half);

    wire        clk;
    wire        rst;
    wire        mic_sck;
    wire        mic_ws;
    wire        mic_lr;
    wire        sio_clk;
    wire        sio_stb;
    wire        sio_data;
    wire  [7:0] led;

    logic        mic_sd;
    logic        tm_drive_en;
    logic        tm_drive_val;
    logic [23:0] pending [$];          // Words waiting for the microphone
    logic [31:0] rng_state = 32'hb6e720f5;
    logic [22:0] exp_mag  = '0;
    logic [22:0] exp_peak = '0;
    logic        exp_live = 1'b0;
    logic [7:0]  key_pattern = '0;
    logic [7:0]  dec_digits [8];       // Raw hgfedcba bytes
    logic [7:0]  dec_leds;
    int          frames_done = 0;
    int          error_count = 0;
    int          cycle_count = 0;

    tb_clock_gen i_clock_gen (.clk (clk), .rst (rst));

    board_specific_top #(.sck_half (sck_half), .sio_half (sio_half)) dut0
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   ),
        .mic_sd   ( mic_sd   ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data ),
        .led      ( led      )
    );

    pullup (sio_data);
    assign sio_data = tm_drive_en ? tm_drive_val : 1'bz;

    initial
    begin
        mic_sd       = 1'b0;
        tm_drive_en  = 1'b0;
        tm_drive_val = 1'b0;
    end

    function automatic logic [31:0] xorshift32 (input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Common-cathode glyphs with segment a in bit 0
    function automatic logic [7:0] glyph (input logic [3:0] v);
        case (v)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;
            4'hC: return 8'h39;
            4'hD: return 8'h5E;
            4'hE: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    function automatic logic [22:0] magnitude (input logic [23:0] w);
        logic [23:0] a;
        a = w [23] ? (~ w + 24'd1) : w;
        if (a [23])
            return 23'h7FFFFF;     // Only -2^23 lands here
        return a [22:0];
    endfunction

    task automatic check_value (input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_failure (input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    // Microphone model that counts sck falls and checks ws and lr on each of them
    always @ (posedge clk)
    begin : mic_model
        logic [5:0]  cnt;
        logic [5:0]  cnt_next;
        logic        sck_prev;
        logic [23:0] word;
        if (rst)
        begin
            cnt      = '0;
            sck_prev = 1'b0;
            word     = '0;
        end
        else
        begin
            if (sck_prev && ! mic_sck)
            begin
                cnt_next = cnt + 6'd1;
                cnt      = cnt_next;
                check_value ("mic_ws", mic_ws, cnt_next >= 6'd32);   // High for the right half
                check_value ("mic_lr", mic_lr, 1'b0);
                if (cnt_next == 6'd1 && pending.size () > 0)
                    word = pending.pop_front ();
                if (cnt_next >= 6'd1 && cnt_next <= 6'd24)
                    mic_sd <= word [24 - cnt_next];
                else
                    mic_sd <= 1'b0;
            end
            sck_prev = mic_sck;
        end
    end

    // TM1638 model that decodes written bytes and answers the key read
    always @ (posedge clk)
    begin : tm_model
        logic       stb_prev;
        logic       sclk_prev;
        logic [7:0] shreg;
        logic [7:0] bytes [24];
        int         nbytes;
        int         gbytes;
        int         bitc;
        int         grp;
        int         gsize [4];
        int         b;
        if (rst)
        begin
            stb_prev  = 1'b1;
            sclk_prev = 1'b1;
            nbytes    = 0;
            gbytes    = 0;
            bitc      = 0;
            grp       = 0;
            tm_drive_en <= 1'b0;
        end
        else
        begin
            if (! sclk_prev && sio_clk && ! sio_stb)
            begin
                shreg = { sio_data, shreg [7:1] };   // LSB arrives first
                if (bitc == 7)
                begin
                    if (nbytes < 24)
                        bytes [nbytes] = shreg;
                    nbytes++;
                    gbytes++;
                    bitc = 0;
                end
                else
                    bitc++;
            end
            if (sclk_prev && ! sio_clk && ! sio_stb && grp == 3 && gbytes >= 1)
            begin
                b = gbytes - 1;
                tm_drive_en  <= 1'b1;
                tm_drive_val <= bitc == 0 ? key_pattern [2 * b]
                              : bitc == 4 ? key_pattern [2 * b + 1] : 1'b0;
            end
            if (stb_prev && ! sio_stb)
                bitc = 0;
            if (! stb_prev && sio_stb)
            begin
                tm_drive_en <= 1'b0;
                gsize [grp] = gbytes;
                gbytes = 0;
                grp++;
                if (grp == 4)
                begin
                    if (nbytes != 24 || gsize [0] != 1 || gsize [1] != 17
                        || gsize [2] != 1 || gsize [3] != 5)
                        report_failure ($sformatf("frame has %0d bytes in wrong groups", nbytes));
                    else
                    begin
                        if (bytes [0] != 8'h40)
                            report_failure ($sformatf("byte 0 is %h, not write command", bytes [0]));
                        if (bytes [1] != 8'hC0)
                            report_failure ($sformatf("byte 1 is %h, not address 0", bytes [1]));
                        if (bytes [18] != 8'h8F)
                            report_failure ($sformatf("byte 18 is %h, not display on", bytes [18]));
                        if (bytes [19] != 8'h42)
                            report_failure ($sformatf("byte 19 is %h, not key read", bytes [19]));
                        for (int i = 0; i < 8; i++)
                        begin
                            dec_digits [i] = bytes [2 + 2 * i];
                            dec_leds [i]   = bytes [3 + 2 * i][0];
                        end
                    end
                    frames_done++;
                    grp    = 0;
                    nbytes = 0;
                end
            end
            stb_prev  = sio_stb;
            sclk_prev = sio_clk;
        end
    end

    always @ (posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit)
        begin
            $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d, plus the timeout", error_count);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic wait_frames (input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target)
            @ (negedge clk);
    endtask

    task automatic queue_word (input logic [23:0] w);
        logic [22:0] m;
        pending.push_back (w);
        m = magnitude (w);
        exp_mag = m;
        if (m > exp_peak)
            exp_peak = m;
    endtask

    task automatic send_batch (input int n);
        logic signed [23:0] s;
        for (int i = 0; i < n; i++)
        begin
            rng_state = xorshift32 (rng_state);
            s = rng_state [23:0];
            s = s >>> rng_state [27:24];    // Spread the levels over the bar
            queue_word (s);
        end
    endtask

    task automatic check_display ();
        logic [23:0] shown;
        logic [7:0]  exp_leds;
        int          lead;
        int          k;
        shown = exp_live ? exp_mag : exp_peak;
        for (int i = 0; i < 6; i++)
            check_value ($sformatf("digit %0d", i), dec_digits [i], glyph (shown [4 * i +: 4]));
        check_value ("digit 6", dec_digits [6], 8'h00);
        check_value ("digit 7", dec_digits [7], glyph (exp_live ? 4'h1 : 4'hE));
        lead = -1;
        for (int i = 0; i < 23; i++)
            if (shown [i])
                lead = i;
        k = lead - 14;
        if (k < 0)
            k = 0;
        if (k > 8)
            k = 8;
        exp_leds = k == 0 ? 8'h00 : 8'hFF >> (8 - k);
        check_value ("leds", dec_leds, exp_leds);
        check_value ("led", led, exp_leds);
    endtask

    // Frame after two full frames reflects every queued word
    task automatic settle_and_check ();
        while (pending.size () > 0)
            @ (negedge clk);
        wait_frames (3);
        check_display ();
    endtask

    task automatic press_key (input int key, input int frames);
        key_pattern [key] = 1'b1;
        wait_frames (frames);
        key_pattern [key] = 1'b0;
        wait_frames (2);
    endtask

    initial
    begin
        @ (posedge clk);
        @ (negedge clk);
        while (rst)
        begin
            check_value ("sio_stb", sio_stb, 1'b1);
            @ (negedge clk);
        end

        wait_frames (1);
        check_display ();

        for (int i = 0; i < 5; i++)
        begin
            send_batch (3);
            settle_and_check ();
        end
        queue_word (24'h800000);
        send_batch (1);
        settle_and_check ();

        queue_word (24'h000000);    // Silence so the cleared peak stays at zero
        settle_and_check ();
        press_key (0, 2);
        exp_peak = '0;
        settle_and_check ();
        for (int i = 0; i < 2; i++)
        begin
            send_batch (3);
            settle_and_check ();
        end

        key_pattern [1] = 1'b1;     // Held over several frames
        wait_frames (2);
        exp_live = 1'b1;
        settle_and_check ();
        wait_frames (1);            // Next frame keeps the same mode
        check_display ();
        send_batch (3);
        settle_and_check ();
        key_pattern [1] = 1'b0;
        wait_frames (2);
        for (int i = 0; i < 3; i++)
        begin
            send_batch (2);
            settle_and_check ();
        end

        press_key (1, 2);
        exp_live = 1'b0;
        settle_and_check ();

        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~ clk;    // 20 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (3)
            @ (posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* source/board_specific_top.sv */
`default_nettype none

module board_specific_top
    import mic_meter_pkg::*;
#(
    parameter int sck_half = 10,    // 2.5 MHz sck from 50 MHz
    parameter int sio_half = 25     // 1 MHz sio_clk
)
(
    input  wire               clk,
    input  wire               rst,

    output wire               mic_sck,
    output wire               mic_ws,
    output wire               mic_lr,
    input  wire               mic_sd,

    output wire               sio_clk,
    output wire               sio_stb,
    inout  wire               sio_data,

    output wire [n_led - 1:0] led
);

    sample_t sample;
    logic    sample_valid;

    display_if disp ();

    inmp441_mic_i2s_receiver
    # (
        .sck_half     ( sck_half     )
    )
    i_microphone
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .lr           ( mic_lr       ),
        .sd           ( mic_sd       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    level_meter i_level_meter
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .disp         ( disp         )
    );

    tm1638_board_controller
    # (
        .sio_half     ( sio_half     )
    )
    i_tm1638
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .disp         ( disp         ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data     ( sio_data     )
    );

    assign led = disp.leds;     // Board LEDs mirror the bar

endmodule

`default_nettype wire

/* source/tm1638_board_controller.sv */
`default_nettype none

module tm1638_board_controller
    import mic_meter_pkg::*;
#(
    parameter int sio_half = 25
)
(
    input  wire      clk,
    input  wire      rst,
    display_if.panel disp,
    output logic     sio_clk,
    output logic     sio_stb,
    inout  wire      sio_data
);

    localparam int w_tmr       = sio_half > 1 ? $clog2 (sio_half) : 1;
    localparam int n_bytes     = 24;    // Command, data and key bytes of a frame
    localparam int idx_data    = 2;
    localparam int idx_last    = 17;    // Last display data byte
    localparam int idx_disp_on = 18;
    localparam int idx_read    = 19;
    localparam int idx_keys    = 20;

    typedef enum logic [2:0]
    {
        st_load,
        st_start,
        st_low,
        st_high,
        st_end
    }
    state_t;

    state_t                     state;
    logic [w_tmr      - 1:0]    timer;
    logic                       tick;
    logic [            4:0]     byte_idx;
    logic [            4:0]     next_idx;     // Byte that the shifter loads next
    logic [            2:0]     bit_idx;
    logic [            3:0]     data_addr;
    logic [            1:0]     key_byte;
    logic [            7:0]     tx_byte;
    logic [            7:0]     tx_sr;
    logic                       data_oe;
    logic                       group_end;
    logic                       reading;
    logic                       reading_next;
    logic [n_digit - 1:0][7:0]  seg_snap;     // hgfedcba
    logic [n_led   - 1:0]       led_snap;
    logic [n_key   - 1:0]       keys_acc;

    assign tick = timer == '0;

    always_ff @ (posedge clk)
        if (rst || state == st_load || tick)
            timer <= w_tmr'(sio_half - 1);
        else
            timer <= timer - 1'b1;

    assign next_idx     = state == st_high ? byte_idx + 5'd1 : byte_idx;
    assign data_addr    = 4'(next_idx - idx_data);
    assign key_byte     = 2'(byte_idx - idx_keys);
    assign reading      = byte_idx >= idx_keys;
    assign reading_next = next_idx >= idx_keys;
    assign group_end    = byte_idx == 0 || byte_idx == idx_last
                       || byte_idx == idx_disp_on || byte_idx == n_bytes - 1;

    always_comb
        if (next_idx == 0)
            tx_byte = cmd_write_auto;
        else if (next_idx == 1)
            tx_byte = cmd_addr_0;
        else if (next_idx <= idx_last)
            tx_byte = data_addr [0] ? { 7'b0, led_snap [data_addr [3:1]] }
                                    : seg_snap [data_addr [3:1]];
        else if (next_idx == idx_disp_on)
            tx_byte = cmd_display_on;
        else if (next_idx == idx_read)
            tx_byte = cmd_read_keys;
        else
            tx_byte = '1;                     // Key bytes, bus released

    always_ff @ (posedge clk)
        if (rst)
        begin
            state           <= st_load;
            byte_idx        <= '0;
            bit_idx         <= '0;
            sio_clk         <= 1'b1;
            sio_stb         <= 1'b1;
            data_oe         <= 1'b0;
            disp.keys       <= '0;
            disp.keys_valid <= 1'b0;
        end
        else
        begin
            disp.keys_valid <= 1'b0;

            case (state)
                st_load:
                begin
                    byte_idx <= '0;
                    sio_stb  <= 1'b0;
                    state    <= st_start;
                end

                st_start:
                    if (tick)
                    begin
                        sio_clk <= 1'b0;
                        bit_idx <= '0;
                        data_oe <= ~ reading_next;
                        state   <= st_low;
                    end

                st_low:
                    if (tick)
                    begin
                        sio_clk <= 1'b1;
                        state   <= st_high;

                        if (byte_idx == n_bytes - 1 && bit_idx == 3'd7)
                        begin
                            disp.keys       <= keys_acc;
                            disp.keys_valid <= 1'b1;
                        end
                    end

                st_high:
                    if (tick)
                    begin
                        if (bit_idx != 3'd7)
                        begin
                            sio_clk <= 1'b0;
                            bit_idx <= bit_idx + 1'b1;
                            state   <= st_low;
                        end
                        else if (group_end)
                        begin
                            sio_stb  <= 1'b1;           // Group done
                            byte_idx <= byte_idx + 1'b1;
                            state    <= st_end;
                        end
                        else
                        begin
                            sio_clk  <= 1'b0;
                            bit_idx  <= '0;
                            byte_idx <= byte_idx + 1'b1;
                            data_oe  <= ~ reading_next;
                            state    <= st_low;
                        end
                    end

                st_end:
                    if (tick)
                    begin
                        if (byte_idx == n_bytes)
                        begin
                            state <= st_load;
                        end
                        else
                        begin
                            sio_stb <= 1'b0;
                            state   <= st_start;
                        end
                    end

                default:
                    state <= st_load;
            endcase
        end

    // LSB first, next bit appears as sio_clk falls
    always_ff @ (posedge clk)
        if (tick && (state == st_start || (state == st_high && bit_idx == 3'd7)))
            tx_sr <= tx_byte;
        else if (tick && state == st_high)
            tx_sr <= tx_sr >> 1;

    assign sio_data = data_oe ? tx_sr [0] : 1'bz;

    // Bit 0 and bit 4 of each key byte
    always_ff @ (posedge clk)
        if (tick && state == st_low && reading)
        begin
            if (bit_idx == 3'd0)
                keys_acc [{ key_byte, 1'b0 }] <= sio_data;
            else if (bit_idx == 3'd4)
                keys_acc [{ key_byte, 1'b1 }] <= sio_data;
        end

    always_ff @ (posedge clk)
        if (state == st_load)
        begin
            for (int i = 0; i < n_digit; i ++)
                for (int j = 0; j < 8; j ++)
                    seg_snap [i][j] <= disp.digits [i][7 - j];

            led_snap <= disp.leds;
        end

endmodule

`default_nettype wire

/* source/level_meter.sv */
`default_nettype none

module level_meter
    import mic_meter_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire sample_t sample,
    input  wire          sample_valid,
    display_if.meter     disp
);

    localparam int n_hex   = 6;     // Digits that carry the value
    localparam int bar_min = 14;    // Leading one at this bit gives an empty bar

    logic [w_sample  - 1:0] abs_value;
    mag_t                   mag_new;
    mag_t                   mag_q;
    mag_t                   peak_q;
    mag_t                   peak_base;
    mag_t                   shown;
    logic                   mode_live;
    logic [n_key     - 1:0] keys_prev;
    logic [n_key     - 1:0] key_rise;
    logic [4 * n_hex - 1:0] shown_hex;
    int                     lead;
    int                     bar_len;

    assign abs_value = sample [w_sample - 1] ? w_sample'(- sample) : sample;
    assign mag_new   = abs_value [w_sample - 1] ? '1 : abs_value [w_mag - 1:0];  // -2^23 saturates

    assign key_rise  = disp.keys_valid ? (disp.keys & ~ keys_prev) : '0;
    assign peak_base = key_rise [0] ? '0 : peak_q;     // Key 0 clears

    always_ff @ (posedge clk)
        if (rst)
        begin
            mag_q     <= '0;
            peak_q    <= '0;
            mode_live <= 1'b0;
            keys_prev <= '0;
        end
        else
        begin
            if (disp.keys_valid)
                keys_prev <= disp.keys;

            if (key_rise [1])
                mode_live <= ~ mode_live;

            if (sample_valid)
                mag_q <= mag_new;

            if (sample_valid && mag_new > peak_base)
                peak_q <= mag_new;
            else
                peak_q <= peak_base;
        end

    assign shown = mode_live ? mag_q : peak_q;

    always_comb
    begin
        shown_hex = (4 * n_hex)'(shown);

        for (int i = 0; i < n_hex; i ++)
            disp.digits [i] = hex_to_seg (shown_hex [4 * i +: 4]);

        disp.digits [6] = '0;       // Blank gap
        disp.digits [7] = hex_to_seg (mode_live ? 4'h1 : 4'hE);
    end

    // Bar length follows the position of the leading one
    always_comb
    begin
        lead = -1;

        for (int i = 0; i < w_mag; i ++)
            if (shown [i])
                lead = i;

        bar_len = lead - bar_min;

        if (bar_len < 0)
            bar_len = 0;
        else if (bar_len > n_led)
            bar_len = n_led;

        for (int j = 0; j < n_led; j ++)
            disp.leds [j] = j < bar_len;
    end

endmodule

`default_nettype wire

/* source/inmp441_mic_i2s_receiver.sv */
`default_nettype none

module inmp441_mic_i2s_receiver
    import mic_meter_pkg::*;
#(
    parameter int sck_half = 10
)
(
    input  wire     clk,
    input  wire     rst,
    output logic    sck,
    output logic    ws,
    output logic    lr,
    input  wire     sd,
    output sample_t sample,
    output logic    sample_valid
);

    localparam int w_div = sck_half > 1 ? $clog2 (sck_half) : 1;

    logic [w_div    - 1:0] div_cnt;
    logic                  sck_toggle;
    logic                  sck_rise;
    logic                  sck_fall;
    logic [           5:0] bit_cnt;      // sck period within the 64-period frame
    logic                  capture;
    logic [w_sample - 1:0] shift_reg;

    assign sck_toggle = div_cnt == w_div'(sck_half - 1);
    assign sck_rise   = sck_toggle & ~ sck;
    assign sck_fall   = sck_toggle &   sck;

    always_ff @ (posedge clk)
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_toggle)
        begin
            div_cnt <= '0;
            sck     <= ~ sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end

    // ws and the frame position move on the falling edge of sck
    always_ff @ (posedge clk)
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;

    assign ws = bit_cnt [5];    // Low for the left half
    assign lr = 1'b0;           // Microphone answers on the left channel

    // MSB sits on the second rising edge after ws falls, LSB on the 25th
    assign capture = sck_rise & ~ ws
                   & (bit_cnt >= 6'd1) & (bit_cnt <= 6'(w_sample));

    always_ff @ (posedge clk)
        if (capture)
            shift_reg <= { shift_reg [w_sample - 2:0], sd };

    always_ff @ (posedge clk)
        if (rst)
            sample_valid <= 1'b0;
        else
            sample_valid <= capture & (bit_cnt == 6'(w_sample));   // Last bit in

    assign sample = shift_reg;  // Stable until the next frame's MSB

endmodule

`default_nettype wire

/* source/display_if.sv */
`default_nettype none

// Display contents go out to the panel, key state comes back
interface display_if
    import mic_meter_pkg::*;
();

    seg_t [n_digit - 1:0] digits;       // Digit 0 is the rightmost
    logic [n_led   - 1:0] leds;
    logic [n_key   - 1:0] keys;
    logic                 keys_valid;   // One cycle per panel frame

    modport meter
    (
        output digits,
        output leds,
        input  keys,
        input  keys_valid
    );

    modport panel
    (
        input  digits,
        input  leds,
        output keys,
        output keys_valid
    );

endinterface

`default_nettype wire

/* source/mic_meter_pkg.sv */
`default_nettype none

package mic_meter_pkg;

    localparam int w_sample = 24;
    localparam int w_mag    = 23;
    localparam int n_digit  = 8;
    localparam int n_led    = 8;
    localparam int n_key    = 8;

    typedef logic signed [w_sample - 1:0] sample_t;
    typedef logic        [w_mag    - 1:0] mag_t;
    typedef logic        [           7:0] seg_t;     // abcdefgh, a is the MSB

    localparam logic [7:0] cmd_write_auto = 8'h40;   // Data write, auto increment
    localparam logic [7:0] cmd_read_keys  = 8'h42;
    localparam logic [7:0] cmd_addr_0     = 8'hC0;
    localparam logic [7:0] cmd_display_on = 8'h8F;   // Display on, full brightness

    function automatic seg_t hex_to_seg (input logic [3:0] value);
        case (value)
            4'h0:    return 8'hFC;
            4'h1:    return 8'h60;
            4'h2:    return 8'hDA;
            4'h3:    return 8'hF2;
            4'h4:    return 8'h66;
            4'h5:    return 8'hB6;
            4'h6:    return 8'hBE;
            4'h7:    return 8'hE0;
            4'h8:    return 8'hFE;
            4'h9:    return 8'hF6;
            4'hA:    return 8'hEE;
            4'hB:    return 8'h3E;   // Lower case b
            4'hC:    return 8'h9C;
            4'hD:    return 8'h7A;   // Lower case d
            4'hE:    return 8'h9E;
            default: return 8'h8E;
        endcase
    endfunction

endpackage

`default_nettype wire
